// File: hw/jstkPkg.sv
package jstkPkg;

	// ========================================
	// Data widths
	// ========================================

	typedef logic [7:0]  byteT;          // One SPI byte
	typedef logic [9:0]  axisT;          // One joystick axis sample
	typedef logic [39:0] packetT;        // Five bytes, first byte on top
	typedef logic [2:0]  byteCountT;     // Bytes done in a transaction

	// Steering output encoding
	typedef enum logic [1:0] {
		dirStraight = 2'd0,
		dirRight    = 2'd1,
		dirBack     = 2'd2,
		dirLeft     = 2'd3
	} directionT;

	// ========================================
	// Protocol constants
	// ========================================

	localparam byteT      JSTK_CMD     = 8'h80;  // LED bits cleared
	localparam byteCountT PACKET_BYTES = 3'd5;   // Bytes per joystick read

	// Decode thresholds, raw 10-bit counts
	localparam axisT X_FORWARD  = 10'd550;
	localparam axisT X_BACKWARD = 10'd450;
	localparam axisT Y_LOW      = 10'd320;
	localparam axisT Y_HIGH     = 10'd720;

	// ========================================
	// FSM encodings
	// ========================================

	// Byte engine
	typedef enum logic [1:0] {
		spiIdle,
		spiShift,     // SCLK toggling, 8 bits
		spiFinish     // Drop busy after done
	} spiStateT;

	// Packet controller
	typedef enum logic [2:0] {
		pktIdle,
		pktSelect,    // SS low, setup cycle
		pktStart,
		pktWait,      // Byte in flight
		pktStore,
		pktDone
	} pktStateT;

endpackage

// File: hw/pollTimer.sv
`timescale 1ns/1ps

module pollTimer #(
	parameter int POLL_PERIOD = 20000000    // Clocks between polls
) (
	input  logic CLK,
	input  logic RST,
	output logic pollTick                   // One-cycle start request
);

	// Counter sized for the reload value
	localparam int CNT_W = (POLL_PERIOD > 1) ? $clog2(POLL_PERIOD) : 1;

	logic [CNT_W-1:0] count;

	// Down counter, tick registered off the zero state
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			count    <= CNT_W'(POLL_PERIOD - 1);
			pollTick <= 1'b0;
		end else begin
			pollTick <= (count == '0);
			if (count == '0) begin
				count <= CNT_W'(POLL_PERIOD - 1);    // Reload for next period
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// Tick is a strobe, not a level
	tickSinglePulse: assert property (
		@(posedge CLK) disable iff (RST)
		pollTick |=> !pollTick
	) else $error("pollTick held for two cycles");

endmodule

// File: hw/spiByteEngine.sv
`timescale 1ns/1ps

module spiByteEngine
	import jstkPkg::*;
#(
	parameter int SCLK_HALF = 750           // Clocks per SCLK half period
) (
	input  logic CLK,
	input  logic RST,
	input  logic byteStart,                 // Pulse, accepted when idle
	input  byteT txByte,
	output logic busy,
	output logic done,                      // Pulse, rxByte valid
	output byteT rxByte,
	input  logic MISO,
	output logic MOSI,
	output logic SCLK                       // Registered, idles low
);

	localparam int HALF_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

	// ========================================
	// Control state
	// ========================================

	spiStateT         state;
	logic [HALF_W-1:0] halfCnt;              // Position in current half
	logic [3:0]       bitCnt;               // Rising edges so far
	byteT             txReg;
	byteT             rxReg;
	logic             halfEnd;
	logic             sclkRise;

	assign halfEnd  = (halfCnt == HALF_W'(SCLK_HALF - 1));
	assign sclkRise = (state == spiShift) && halfEnd && !SCLK;

	// MSB first on the wire
	assign MOSI   = txReg[7];
	assign rxByte = rxReg;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state   <= spiIdle;
			halfCnt <= '0;
			bitCnt  <= '0;
			txReg   <= '0;                  // Keeps MOSI low out of reset
			SCLK    <= 1'b0;
			busy    <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				spiIdle: begin
					if (byteStart) begin
						txReg   <= txByte;  // Bit 7 on MOSI next cycle
						halfCnt <= '0;
						bitCnt  <= '0;
						busy    <= 1'b1;
						state   <= spiShift;
					end
				end

				spiShift: begin
					if (halfEnd) begin
						halfCnt <= '0;
						SCLK    <= ~SCLK;
						if (!SCLK) begin
							bitCnt <= bitCnt + 1'b1;    // Rising edge
						end else begin
							// Falling edge, present next bit
							txReg <= {txReg[6:0], 1'b0};
							if (bitCnt == 4'd8) begin
								done  <= 1'b1;
								state <= spiFinish;
							end
						end
					end else begin
						halfCnt <= halfCnt + 1'b1;
					end
				end

				spiFinish: begin
					busy  <= 1'b0;          // Busy covered the done cycle
					state <= spiIdle;
				end

				default: state <= spiIdle;
			endcase
		end
	end

	// ========================================
	// Receive shift register
	// ========================================

	// Mode 0, slave data stable at rising SCLK
	always_ff @(posedge CLK) begin
		if (sclkRise) begin
			rxReg <= {rxReg[6:0], MISO};
		end
	end

	// Controller must wait for done before restarting
	startWhileBusy: assert property (
		@(posedge CLK) disable iff (RST)
		byteStart |-> !busy
	) else $error("byteStart while engine busy");

	// Clock parked low between bytes
	sclkIdleLow: assert property (
		@(posedge CLK) disable iff (RST)
		(state == spiIdle) |-> !SCLK
	) else $error("SCLK high while engine idle");

endmodule

// File: hw/jstkPacketCtrl.sv
`timescale 1ns/1ps

module jstkPacketCtrl
	import jstkPkg::*;
(
	input  logic   CLK,
	input  logic   RST,
	input  logic   pollTick,
	output logic   byteStart,               // To byte engine
	output byteT   txByte,
	input  logic   busy,
	input  logic   done,
	input  byteT   rxByte,
	output logic   SS,                      // Active low select
	output packetT packet,                  // Held until next packetValid
	output logic   packetValid
);

	pktStateT  state;
	byteCountT byteCnt;
	packetT    accum;                       // Bytes gathered so far

	// Same command in every slot
	assign txByte = JSTK_CMD;

	// ========================================
	// Transaction sequencer
	// ========================================

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state       <= pktIdle;
			byteCnt     <= '0;
			byteStart   <= 1'b0;
			SS          <= 1'b1;
			packetValid <= 1'b0;
		end else begin
			byteStart   <= 1'b0;
			packetValid <= 1'b0;
			case (state)
				pktIdle: begin
					if (pollTick) begin      // Ticks elsewhere dropped
						SS      <= 1'b0;
						byteCnt <= '0;
						state   <= pktSelect;
					end
				end

				pktSelect: state <= pktStart;   // Setup time after SS

				pktStart: begin
					byteStart <= 1'b1;
					state     <= pktWait;
				end

				pktWait: begin
					if (done) begin
						byteCnt <= byteCnt + 1'b1;
						state   <= pktStore;
					end
				end

				pktStore: begin
					if (byteCnt == PACKET_BYTES) begin
						packetValid <= 1'b1;
						state       <= pktDone;
					end else begin
						state <= pktStart;      // Next byte slot
					end
				end

				pktDone: begin
					SS    <= 1'b1;            // Release after packet out
					state <= pktIdle;
				end

				default: state <= pktIdle;
			endcase
		end
	end

	// ========================================
	// Packet assembly
	// ========================================

	always_ff @(posedge CLK) begin
		if (state == pktWait && done) begin
			accum <= {accum[31:0], rxByte};  // First byte ends on top
		end
		if (state == pktStore && byteCnt == PACKET_BYTES) begin
			packet <= accum;
		end
	end

	// Engine only runs inside a select window
	selectCoversByte: assert property (
		@(posedge CLK) disable iff (RST)
		busy |-> !SS
	) else $error("byte engine busy with SS high");

endmodule

// File: hw/directionDecoder.sv
`timescale 1ns/1ps

module directionDecoder
	import jstkPkg::*;
(
	input  logic      CLK,
	input  logic      RST,
	input  packetT    packet,
	input  logic      packetValid,          // Strobe, packet fresh
	output directionT direction,
	output logic      button
);

	axisT axisX;
	axisT axisY;
	logic yInBand;
	logic goStraight;
	logic goBack;

	// ========================================
	// Field extraction
	// ========================================

	// Low byte first, high bits in next byte
	assign axisY = {packet[25:24], packet[39:32]};
	assign axisX = {packet[9:8], packet[23:16]};

	// Inclusive band on Y
	assign yInBand = (axisY >= Y_LOW) && (axisY <= Y_HIGH);

	assign goStraight = (axisX >= X_FORWARD) && yInBand;
	assign goBack     = (axisX <= X_BACKWARD) && yInBand;

	// ========================================
	// Output registers
	// ========================================

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			direction <= dirStraight;
			button    <= 1'b0;
		end else if (packetValid) begin
			button <= packet[1];            // Stick press bit
			// Priority order, dead zone keeps last value
			if (goStraight) begin
				direction <= dirStraight;
			end else if (goBack) begin
				direction <= dirBack;
			end else if (axisY < Y_LOW) begin
				direction <= dirLeft;
			end else if (axisY > Y_HIGH) begin
				direction <= dirRight;
			end
		end
	end

endmodule

// File: hw/jstkTop.sv
`timescale 1ns/1ps

module jstkTop
	import jstkPkg::*;
#(
	parameter int SCLK_HALF   = 750,        // 66.67 kHz SCLK at 100 MHz
	parameter int POLL_PERIOD = 20000000    // 5 Hz poll at 100 MHz
) (
	input  logic      CLK,
	input  logic      RST,
	input  logic      MISO,
	output logic      SS,
	output logic      MOSI,
	output logic      SCLK,
	output directionT direction,
	output logic      button
);

	// ========================================
	// Internal nets
	// ========================================

	logic   pollTick;
	logic   byteStart;
	byteT   txByte;
	logic   busy;
	logic   done;
	byteT   rxByte;
	packetT packet;
	logic   packetValid;

	pollTimer #(
		.POLL_PERIOD (POLL_PERIOD)
	) pollTimer_inst (
		.CLK      (CLK),
		.RST      (RST),
		.pollTick (pollTick)
	);

	jstkPacketCtrl jstkPacketCtrl_inst (
		.CLK         (CLK),
		.RST         (RST),
		.pollTick    (pollTick),
		.byteStart   (byteStart),
		.txByte      (txByte),
		.busy        (busy),
		.done        (done),
		.rxByte      (rxByte),
		.SS          (SS),
		.packet      (packet),
		.packetValid (packetValid)
	);

	// Single byte exchange on the pins
	spiByteEngine #(
		.SCLK_HALF (SCLK_HALF)
	) spiByteEngine_inst (
		.CLK       (CLK),
		.RST       (RST),
		.byteStart (byteStart),
		.txByte    (txByte),
		.busy      (busy),
		.done      (done),
		.rxByte    (rxByte),
		.MISO      (MISO),
		.MOSI      (MOSI),
		.SCLK      (SCLK)
	);

	directionDecoder directionDecoder_inst (
		.CLK         (CLK),
		.RST         (RST),
		.packet      (packet),
		.packetValid (packetValid),
		.direction   (direction),
		.button      (button)
	);

endmodule

// File: test/jstkSlaveModel.sv
`timescale 1ns/1ps

module jstkSlaveModel
	import jstkPkg::*;
(
	input  logic CLK,
	input  logic SS,
	input  logic SCLK,
	input  logic MOSI,
	output logic MISO
);

	byteT misoQueue[$];                     // Bytes to return, oldest first
	byteT mosiBytes[$];                     // Command bytes seen on MOSI
	byteT curByte;
	byteT mosiShift;
	int   bitIdx;                           // Bit of curByte on MISO
	int   riseCount;                        // Rising SCLK in current SS window
	logic ssPrev;
	logic sclkPrev;

	initial begin
		MISO      = 1'b0;
		ssPrev    = 1'b1;
		sclkPrev  = 1'b0;
		riseCount = 0;
		bitIdx    = 7;
		curByte   = '0;
		mosiShift = '0;
	end

	// Empty queue reads as zero
	function automatic byteT nextByte();
		if (misoQueue.size() > 0) begin
			return misoQueue.pop_front();
		end
		return '0;
	endfunction

	task automatic loadBytes(input byteT b0, input byteT b1, input byteT b2,
		input byteT b3, input byteT b4);
		misoQueue.push_back(b0);
		misoQueue.push_back(b1);
		misoQueue.push_back(b2);
		misoQueue.push_back(b3);
		misoQueue.push_back(b4);
	endtask

	task automatic popMosi(output byteT b);
		b = mosiBytes.pop_front();
	endtask

	function automatic int mosiCount();
		return mosiBytes.size();
	endfunction

	// ========================================
	// Pin activity, edges found by sampling
	// ========================================

	always @(posedge CLK) begin
		if (ssPrev && !SS) begin
			riseCount = 0;                  // New window
			curByte   = nextByte();
			bitIdx    = 7;
			MISO     <= curByte[7];
		end else if (!SS) begin
			if (!sclkPrev && SCLK) begin
				mosiShift = {mosiShift[6:0], MOSI};    // MSB first
				riseCount = riseCount + 1;
				if (riseCount % 8 == 0) begin
					mosiBytes.push_back(mosiShift);
				end
			end else if (sclkPrev && !SCLK) begin
				if (bitIdx == 0) begin
					curByte = nextByte();
					bitIdx  = 7;
				end else begin
					bitIdx = bitIdx - 1;
				end
				MISO <= curByte[bitIdx];    // Change on falling SCLK
			end
		end
		ssPrev   = SS;
		sclkPrev = SCLK;
	end

endmodule

// File: test/jstkTb.sv
`timescale 1ns/1ps

module jstkTb
	import jstkPkg::*;
();

	localparam int SCLK_HALF   = 4;
	localparam int POLL_PERIOD = 2000;
	localparam int SS_TIMEOUT  = 3000;      // Cycles, longer than one poll period

	logic        CLK;
	logic        RST;
	logic        MISO;
	logic        SS;
	logic        MOSI;
	logic        SCLK;
	directionT   direction;
	logic        button;

	int          errors;
	int          checks;
	logic [31:0] seed;                      // LCG state
	directionT   expDir;                    // Direction the rule predicts
	logic        expButton;

	jstkTop #(
		.SCLK_HALF   (SCLK_HALF),
		.POLL_PERIOD (POLL_PERIOD)
	) jstkTop_inst (
		.CLK       (CLK),
		.RST       (RST),
		.MISO      (MISO),
		.SS        (SS),
		.MOSI      (MOSI),
		.SCLK      (SCLK),
		.direction (direction),
		.button    (button)
	);

	jstkSlaveModel jstkSlaveModel_inst (
		.CLK  (CLK),
		.SS   (SS),
		.SCLK (SCLK),
		.MOSI (MOSI),
		.MISO (MISO)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;              // 4 ns period
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Reference steering rule, bounds inclusive
	function automatic directionT decodeRule(axisT x, axisT y, directionT prev);
		logic inBand;
		inBand = (y >= Y_LOW) && (y <= Y_HIGH);
		if (x >= X_FORWARD && inBand) begin
			return dirStraight;
		end
		if (x <= X_BACKWARD && inBand) begin
			return dirBack;
		end
		if (y < Y_LOW) begin
			return dirLeft;
		end
		if (y > Y_HIGH) begin
			return dirRight;
		end
		return prev;                        // Dead zone
	endfunction

	task automatic checkValue(input string name, input logic [39:0] actual,
		input logic [39:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic waitForSs(input logic level, output bit ok);
		int cycles;
		cycles = 0;
		while (SS !== level && cycles < SS_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		ok = (SS === level);
		if (!ok) begin
			errors++;
			$display("Timeout: SS did not reach %0b within %0d cycles", level, SS_TIMEOUT);
		end
	endtask

	// One poll, checks frame shape and decoded outputs
	task automatic sendPacket(input byteT b0, input byteT b1, input byteT b2,
		input byteT b3, input byteT b4);
		axisT x;
		axisT y;
		byteT seen;
		bit   ok;
		y = {b1[1:0], b0};
		x = {b3[1:0], b2};
		jstkSlaveModel_inst.loadBytes(b0, b1, b2, b3, b4);
		waitForSs(1'b0, ok);
		if (ok) begin
			waitForSs(1'b1, ok);
		end
		if (ok) begin
			expDir    = decodeRule(x, y, expDir);
			expButton = b4[1];
			checkValue("SCLK rises", jstkSlaveModel_inst.riseCount, 40);
			checkValue("MOSI byte count", jstkSlaveModel_inst.mosiCount(), PACKET_BYTES);
			while (jstkSlaveModel_inst.mosiCount() > 0) begin
				jstkSlaveModel_inst.popMosi(seen);
				checkValue("MOSI", seen, JSTK_CMD);
			end
			checkValue("direction", direction, expDir);
			checkValue("button", button, expButton);
		end
	endtask

	task automatic sendAxes(input axisT x, input axisT y, input logic btn);
		sendPacket(y[7:0], {6'd0, y[9:8]}, x[7:0], {6'd0, x[9:8]}, {6'd0, btn, 1'b0});
	endtask

	task automatic checkIdle();
		checkValue("SS", SS, 1'b1);
		checkValue("SCLK", SCLK, 1'b0);
		checkValue("MOSI", MOSI, 1'b0);
		checkValue("direction", direction, dirStraight);
		checkValue("button", button, 1'b0);
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic testReset();
		@(posedge CLK);
		@(negedge CLK);
		checkIdle();                        // Still in reset
		repeat (2) @(posedge CLK);
		RST <= 1'b0;                        // Released after third edge
		@(negedge CLK);
		checkIdle();
	endtask

	task automatic testFixedPoints();
		sendAxes(10'd600, 10'd500, 1'b0);   // Straight
		sendAxes(10'd400, 10'd500, 1'b0);   // Back
		sendAxes(10'd500, 10'd100, 1'b0);   // Left
		sendAxes(10'd500, 10'd900, 1'b0);   // Right
		sendAxes(10'd600, 10'd320, 1'b0);   // Band edges
		sendAxes(10'd400, 10'd720, 1'b0);
		sendAxes(10'd400, 10'd319, 1'b0);
		sendAxes(10'd600, 10'd721, 1'b0);
	endtask

	task automatic testDeadZone();
		sendAxes(10'd700, 10'd500, 1'b0);
		sendAxes(10'd500, 10'd500, 1'b0);
		checkValue("direction held", direction, dirStraight);
		sendAxes(10'd300, 10'd400, 1'b0);
		sendAxes(10'd451, 10'd600, 1'b0);
		checkValue("direction held", direction, dirBack);
		sendAxes(10'd549, 10'd320, 1'b0);
		checkValue("direction held", direction, dirBack);
	endtask

	task automatic testButton();
		sendAxes(10'd600, 10'd500, 1'b1);
		sendAxes(10'd600, 10'd500, 1'b0);
		sendAxes(10'd600, 10'd500, 1'b1);
		sendPacket(8'd200, 8'h01, 8'd40, 8'h02, 8'hfd);    // Other bits set, press clear
		sendPacket(8'd200, 8'h01, 8'd40, 8'h02, 8'h02);
	endtask

	// Upper bits of the high bytes are noise
	task automatic testRandomAxes();
		logic [31:0] r0;
		logic [31:0] r1;
		for (int i = 0; i < 8; i++) begin
			r0 = nextRand();
			r1 = nextRand();
			sendPacket(r0[7:0], r0[15:8], r0[23:16], r0[31:24], r1[7:0]);
		end
	endtask

	initial begin
		RST       = 1'b1;
		errors    = 0;
		checks    = 0;
		seed      = 32'he438_c726;
		expDir    = dirStraight;
		expButton = 1'b0;
		testReset();
		testFixedPoints();
		testDeadZone();
		testButton();
		testRandomAxes();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: project.f
hw/jstkPkg.sv
hw/pollTimer.sv
hw/spiByteEngine.sv
hw/jstkPacketCtrl.sv
hw/directionDecoder.sv
hw/jstkTop.sv
test/jstkSlaveModel.sv
test/jstkTb.sv

// File: Bender.yml
package:
  name: jstk_reader

sources:
  - hw/jstkPkg.sv
  - hw/pollTimer.sv
  - hw/spiByteEngine.sv
  - hw/jstkPacketCtrl.sv
  - hw/directionDecoder.sv
  - hw/jstkTop.sv
  - target: test
    files:
      - test/jstkSlaveModel.sv
      - test/jstkTb.sv
